/* Makefile */
VERILATOR ?= verilator
TOP       ?= ldst_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= ./obj_dir
VFLAGS    ?= --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass line
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/ldst_control.sv */
`timescale 1ns/100ps
`default_nettype none

module ldst_control
(
	input  logic                clk,
	                            rst_n,

	input  logic                issue,
	                            load,
	                            pre_indexed,
	                            increment,
	                            writeback,
	input  ldst_pkg::reg_list   regs,

	input  ldst_pkg::ctrl_cycle cycle,
	                            next_cycle,
	input  logic                mem_ready,
	input  ldst_pkg::word       rd_value_b,
	                            alu_a,
	                            alu_b,
	                            q_alu,

	output ldst_pkg::ptr        mem_addr,
	output ldst_pkg::word       mem_data_wr,
	                            mem_offset,
	output logic                mem_start,
	                            mem_write,
	                            pop_valid,
	                            ldst_next,
	                            ldst_writeback,
	output ldst_pkg::reg_num    popped
);

	logic pre, up, outstanding;
	ldst_pkg::reg_num pop_lower, pop_upper;
	ldst_pkg::reg_list insn_regs, mem_regs, next_regs_lower, next_regs_upper;

	// Outside a transfer every cycle counts as a completed step
	assign ldst_next = cycle != ldst_pkg::CYCLE_TRANSFER || mem_ready;
	assign mem_data_wr = rd_value_b;

	ldst_pop pop_inst
	(
		.regs(mem_regs),
		.valid(pop_valid),
		.pop_lower(pop_lower),
		.pop_upper(pop_upper),
		.next_lower(next_regs_lower),
		.next_upper(next_regs_upper)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre <= 1'b0;
			up <= 1'b0;
			ldst_writeback <= 1'b0;
			insn_regs <= '0;
			mem_regs <= '0;
			popped <= '0;

			mem_addr <= '0;
			mem_offset <= '0;
			mem_write <= 1'b0;
			mem_start <= 1'b0;
		end else begin
			mem_start <= 1'b0;

			if (cycle == ldst_pkg::CYCLE_IDLE && issue) begin
				pre <= pre_indexed;
				up <= increment;
				ldst_writeback <= writeback;
				insn_regs <= regs;
				mem_regs <= regs;
				mem_write <= !load;
			end else if (next_cycle == ldst_pkg::CYCLE_TRANSFER && ldst_next) begin
				if (cycle == ldst_pkg::CYCLE_ISSUE)
					mem_offset <= alu_b; // Span of the whole block

				// mem_regs keeps only the registers still to be moved
				popped <= up ? pop_lower : pop_upper;
				mem_regs <= up ? next_regs_lower : next_regs_upper;

				mem_addr <= pre ? q_alu[ldst_pkg::WORD_BITS-1:ldst_pkg::ADDR_LSB]
				                : alu_a[ldst_pkg::WORD_BITS-1:ldst_pkg::ADDR_LSB];
				mem_start <= 1'b1;
			end
		end
	end

	// Set from a start until its reply comes back
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			outstanding <= 1'b0;
		else if (mem_start)
			outstanding <= 1'b1;
		else if (mem_ready)
			outstanding <= 1'b0;
	end

	// Only one memory request at a time
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_start |-> !outstanding);

	// The register on the bus belongs to the instruction that was issued
	assert property (@(posedge clk) disable iff (!rst_n)
		cycle == ldst_pkg::CYCLE_TRANSFER |-> insn_regs[popped]);

endmodule

`default_nettype wire

/* design/ldst_pkg.sv */
`default_nettype none

package ldst_pkg;

	localparam int NUM_REGS = 16;
	localparam int WORD_BYTES = 4;
	localparam int WORD_BITS = 32;

	localparam int REG_BITS = $clog2(NUM_REGS);
	localparam int COUNT_BITS = $clog2(NUM_REGS + 1); // Room for a full list
	localparam int ADDR_LSB = $clog2(WORD_BYTES);
	localparam int PTR_BITS = WORD_BITS - ADDR_LSB;

	// Data values and byte addresses
	typedef logic [WORD_BITS-1:0] word;

	// Word address, the byte address without its two low bits
	typedef logic [PTR_BITS-1:0] ptr;

	typedef logic [REG_BITS-1:0] reg_num;

	// Bit i selects register i
	typedef logic [NUM_REGS-1:0] reg_list;

	typedef logic [COUNT_BITS-1:0] reg_count;

	// One-hot so that a corrupted state stands out
	typedef enum logic [3:0] {
		CYCLE_IDLE      = 4'b0001,
		CYCLE_ISSUE     = 4'b0010,
		CYCLE_TRANSFER  = 4'b0100,
		CYCLE_WRITEBACK = 4'b1000
	} ctrl_cycle;

endpackage

`default_nettype wire

/* design/ldst_pop.sv */
`timescale 1ns/100ps
`default_nettype none

module ldst_pop
(
	input  ldst_pkg::reg_list regs,

	output logic              valid,
	output ldst_pkg::reg_num  pop_lower,
	                          pop_upper,
	output ldst_pkg::reg_list next_lower,
	                          next_upper
);

	assign valid = |regs;

	// Scanning downward leaves the lowest set bit in pop_lower
	always_comb begin
		pop_lower = '0;
		for (int i = ldst_pkg::NUM_REGS - 1; i >= 0; i--)
			if (regs[i])
				pop_lower = ldst_pkg::reg_num'(i);
	end

	always_comb begin
		pop_upper = '0;
		for (int i = 0; i < ldst_pkg::NUM_REGS; i++)
			if (regs[i])
				pop_upper = ldst_pkg::reg_num'(i); // Last hit is the highest
	end

	// Clearing the lowest set bit needs no encoder
	assign next_lower = regs & (regs - ldst_pkg::reg_list'(1));

	assign next_upper = regs & ~(ldst_pkg::reg_list'(1) << pop_upper);

endmodule

`default_nettype wire

/* design/ldst_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module ldst_regfile
(
	input  logic             clk,
	                         rst_n,

	input  ldst_pkg::reg_num rd_num_a,
	                         rd_num_b,

	input  logic             ld_en,
	input  ldst_pkg::reg_num ld_num,
	input  ldst_pkg::word    ld_value,

	input  logic             wb_en,
	input  ldst_pkg::reg_num wb_num,
	input  ldst_pkg::word    wb_value,

	output ldst_pkg::word    rd_value_a,
	                         rd_value_b
);

	ldst_pkg::word bank [ldst_pkg::NUM_REGS];

	assign rd_value_a = bank[rd_num_a];
	assign rd_value_b = bank[rd_num_b];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ldst_pkg::NUM_REGS; i++)
				bank[i] <= '0;
		end else if (wb_en)
			bank[wb_num] <= wb_value;
		else if (ld_en)
			bank[ld_num] <= ld_value;
	end

	// Loads finish in transfer, writeback has a cycle of its own
	assert property (@(posedge clk) disable iff (!rst_n)
		!(ld_en && wb_en));

endmodule

`default_nettype wire

/* design/ldst_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module ldst_sequencer
(
	input  logic                clk,
	                            rst_n,

	input  logic                issue,
	                            increment,
	input  ldst_pkg::reg_num    base,
	input  ldst_pkg::reg_list   regs,
	input  ldst_pkg::word       base_value,

	input  logic                ldst_next,
	                            pop_valid,
	                            mem_ready,

	output ldst_pkg::ctrl_cycle cycle,
	                            next_cycle,
	output ldst_pkg::word       alu_a,
	                            alu_b,
	                            q_alu,
	                            wb_value,
	output ldst_pkg::reg_num    wb_num,
	output logic                wb_en,
	                            busy,
	                            done
);

	logic up;
	ldst_pkg::word base_q;

	function automatic ldst_pkg::reg_count count_regs(input ldst_pkg::reg_list list);
		ldst_pkg::reg_count n;
		n = '0;
		for (int i = 0; i < ldst_pkg::NUM_REGS; i++)
			n = n + ldst_pkg::reg_count'(list[i]);
		return n;
	endfunction

	assign busy = cycle != ldst_pkg::CYCLE_IDLE;
	assign wb_en = cycle == ldst_pkg::CYCLE_WRITEBACK;

	assign q_alu = up ? alu_a + ldst_pkg::word'(ldst_pkg::WORD_BYTES)
	                  : alu_a - ldst_pkg::word'(ldst_pkg::WORD_BYTES);
	assign wb_value = up ? base_q + alu_b : base_q - alu_b;

	always_comb begin
		next_cycle = cycle;
		unique case (cycle)
			ldst_pkg::CYCLE_IDLE:
				if (issue)
					next_cycle = ldst_pkg::CYCLE_ISSUE;
			ldst_pkg::CYCLE_ISSUE: // An empty list skips straight to writeback
				next_cycle = pop_valid ? ldst_pkg::CYCLE_TRANSFER : ldst_pkg::CYCLE_WRITEBACK;
			ldst_pkg::CYCLE_TRANSFER:
				if (ldst_next && !pop_valid)
					next_cycle = ldst_pkg::CYCLE_WRITEBACK;
			default:
				next_cycle = ldst_pkg::CYCLE_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= ldst_pkg::CYCLE_IDLE;
			done <= 1'b0;
			up <= 1'b0;
		end else begin
			cycle <= next_cycle;
			done <= cycle == ldst_pkg::CYCLE_WRITEBACK; // Lands as busy falls
			if (cycle == ldst_pkg::CYCLE_IDLE && issue)
				up <= increment;
		end
	end

	always_ff @(posedge clk) begin
		if (cycle == ldst_pkg::CYCLE_IDLE && issue) begin
			alu_a <= base_value;
			base_q <= base_value;
			alu_b <= ldst_pkg::word'(count_regs(regs)) * ldst_pkg::word'(ldst_pkg::WORD_BYTES);
			wb_num <= base;
		end else if (next_cycle == ldst_pkg::CYCLE_TRANSFER && ldst_next)
			alu_a <= q_alu; // Same step the control block takes for mem_addr
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		cycle inside {ldst_pkg::CYCLE_IDLE, ldst_pkg::CYCLE_ISSUE,
		              ldst_pkg::CYCLE_TRANSFER, ldst_pkg::CYCLE_WRITEBACK});

	// Memory only answers a request made during the transfer phase
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_ready |-> cycle == ldst_pkg::CYCLE_TRANSFER);

endmodule

`default_nettype wire

/* design/ldst_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module ldst_unit
(
	input  logic              clk,
	                          rst_n,

	input  logic              issue,
	                          load,
	                          pre_indexed,
	                          increment,
	                          writeback,
	input  ldst_pkg::reg_num  base,
	input  ldst_pkg::reg_list regs,
	output logic              busy,
	                          done,

	output ldst_pkg::ptr      mem_addr,
	output ldst_pkg::word     mem_data_wr,
	output logic              mem_write,
	                          mem_start,
	input  logic              mem_ready,
	input  ldst_pkg::word     mem_data_rd,

	input  ldst_pkg::reg_num  dbg_num,
	output ldst_pkg::word     dbg_value
);

	ldst_pkg::ctrl_cycle cycle, next_cycle;
	ldst_pkg::word alu_a, alu_b, q_alu, wb_value, base_value, rd_value_b;
	ldst_pkg::reg_num popped, wb_num, rd_num_b;
	logic ldst_next, pop_valid, ldst_writeback, wb_en, ld_en, rf_wb_en;

	assign rd_num_b = busy ? popped : dbg_num; // Debug reads only while idle
	assign dbg_value = rd_value_b;

	assign ld_en = mem_ready && !mem_write;
	assign rf_wb_en = wb_en && ldst_writeback;

	ldst_sequencer sequencer_inst
	(
		.clk, .rst_n,
		.issue, .increment, .base, .regs, .base_value,
		.ldst_next, .pop_valid, .mem_ready,
		.cycle, .next_cycle, .alu_a, .alu_b, .q_alu,
		.wb_value, .wb_num, .wb_en, .busy, .done
	);

	ldst_control control_inst
	(
		.clk, .rst_n,
		.issue, .load, .pre_indexed, .increment, .writeback, .regs,
		.cycle, .next_cycle, .mem_ready, .rd_value_b, .alu_a, .alu_b, .q_alu,
		.mem_addr, .mem_data_wr,
		.mem_offset(),
		.mem_start, .mem_write, .pop_valid, .ldst_next, .ldst_writeback, .popped
	);

	ldst_regfile regfile_inst
	(
		.clk, .rst_n,
		.rd_num_a(base),
		.rd_num_b(rd_num_b),
		.ld_en(ld_en),
		.ld_num(popped),
		.ld_value(mem_data_rd),
		.wb_en(rf_wb_en),
		.wb_num(wb_num),
		.wb_value(wb_value),
		.rd_value_a(base_value),
		.rd_value_b(rd_value_b)
	);

endmodule

`default_nettype wire

/* tb.f */
design/ldst_pkg.sv
design/ldst_pop.sv
design/ldst_control.sv
design/ldst_sequencer.sv
design/ldst_regfile.sv
design/ldst_unit.sv
verif/ldst_tb_clock.sv
verif/ldst_tb.sv

/* verif/ldst_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ldst_tb;

	localparam int DRIVE_DELAY = 2;
	localparam int TIMEOUT = 40;
	localparam int RANDOM_RUNS = 12;

	logic clk, rst_n;
	logic issue, load, pre_indexed, increment, writeback, busy, done;
	logic mem_write, mem_start, mem_ready;
	ldst_pkg::reg_num base, dbg_num;
	ldst_pkg::reg_list regs;
	ldst_pkg::ptr mem_addr;
	ldst_pkg::word mem_data_wr, mem_data_rd, dbg_value;

	ldst_pkg::word ref_regs [ldst_pkg::NUM_REGS];
	ldst_pkg::word mem_model [ldst_pkg::ptr];
	int exp_reg [$];
	ldst_pkg::word exp_addr [$];
	logic [31:0] lfsr = 32'h47513383;

	ldst_tb_clock clock_inst (.clk, .rst_n);

	ldst_unit ldst_unit_inst
	(
		.clk, .rst_n,
		.issue, .load, .pre_indexed, .increment, .writeback, .base, .regs, .busy, .done,
		.mem_addr, .mem_data_wr, .mem_write, .mem_start, .mem_ready, .mem_data_rd,
		.dbg_num, .dbg_value
	);

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			fail_stop($sformatf("Fail %s: got %h, expected %h", name, got, expected));
	endtask

	task automatic step();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++)
			value = {value[30:0], lfsr_bit()};
		return value;
	endfunction

	function automatic ldst_pkg::word mem_read(input ldst_pkg::ptr addr);
		if (mem_model.exists(addr))
			return mem_model[addr];
		return {addr, 2'b00} ^ {addr[14:0], addr[29:13]} ^ 32'h5a3c96e1; // Untouched word
	endfunction

	// Expected register order and byte address of every transfer
	task automatic plan_transfers(input logic pre, inc, input ldst_pkg::reg_list list,
			input ldst_pkg::word base_value);
		ldst_pkg::word addr;
		int r;
		exp_reg.delete();
		exp_addr.delete();
		addr = pre ? (inc ? base_value + 32'd4 : base_value - 32'd4) : base_value;
		for (int k = 0; k < ldst_pkg::NUM_REGS; k++) begin
			r = inc ? k : ldst_pkg::NUM_REGS - 1 - k;
			if (list[r]) begin
				exp_reg.push_back(r);
				exp_addr.push_back(addr);
				addr = inc ? addr + 32'd4 : addr - 32'd4;
			end
		end
	endtask

	task automatic compare_registers();
		for (int i = 0; i < ldst_pkg::NUM_REGS; i++) begin
			step();
			dbg_num = ldst_pkg::reg_num'(i);
			#5;
			check_value($sformatf("dbg_value of r%0d", i), dbg_value, ref_regs[i]);
		end
	endtask

	task automatic answer_memory(input ldst_pkg::word data, input logic disturb);
		int delay;
		ldst_pkg::ptr held_addr;
		ldst_pkg::word held_data;
		delay = 1 + int'(random_bits(2));
		held_addr = mem_addr;
		held_data = mem_data_wr;
		if (disturb) begin
			check_value("busy", 32'(busy), 1);
			issue = 1'b1; // A second instruction that has to be dropped
			regs = ~regs;
			load = ~load;
		end
		for (int k = 0; k < delay; k++) begin
			step();
			issue = 1'b0;
			check_value("mem_start while outstanding", 32'(mem_start), 0);
			check_value("mem_addr while waiting", 32'(mem_addr), 32'(held_addr));
			check_value("mem_data_wr while waiting", mem_data_wr, held_data);
		end
		mem_ready = 1'b1;
		mem_data_rd = data;
		step();
		mem_ready = 1'b0;
	endtask

	task automatic run_insn(input logic ld, pre, inc, wb, input ldst_pkg::reg_num b,
			input ldst_pkg::reg_list list, input logic disturb);
		ldst_pkg::word base_value, data;
		int idx, cycles, waited, n;
		logic finished;
		base_value = ref_regs[b];
		plan_transfers(pre, inc, list, base_value);
		n = exp_reg.size();
		step();
		check_value("busy", 32'(busy), 0);
		issue = 1'b1;
		load = ld;
		pre_indexed = pre;
		increment = inc;
		writeback = wb;
		base = b;
		regs = list;
		step();
		issue = 1'b0;
		cycles = 1;
		idx = 0;
		waited = 0;
		finished = 1'b0;
		while (!finished) begin
			if (mem_start) begin
				if (idx >= n)
					fail_stop("mem_start was raised after the last register of the list");
				if (idx == 0)
					check_value("cycles from issue to mem_start", cycles, 2);
				check_value("mem_addr", 32'(mem_addr), exp_addr[idx] >> 2);
				check_value("mem_write", 32'(mem_write), 32'(!ld));
				data = mem_read(mem_addr);
				if (!ld) begin
					check_value("mem_data_wr", mem_data_wr, ref_regs[exp_reg[idx]]);
					mem_model[mem_addr] = mem_data_wr;
				end
				answer_memory(data, disturb && idx == 0);
				if (ld)
					ref_regs[exp_reg[idx]] = data;
				idx++;
				waited = 0;
				if (idx < n)
					check_value("mem_start after mem_ready", 32'(mem_start), 1);
			end else if (done) begin
				check_value("transfer count", idx, n);
				if (n > 0)
					check_value("cycles from last mem_ready to done", waited, 1);
				check_value("busy", 32'(busy), 0);
				finished = 1'b1;
			end else if (waited == TIMEOUT)
				fail_stop("Timed out waiting for mem_start or done");
			else begin
				waited++;
				cycles++;
				step();
			end
		end
		step();
		check_value("done", 32'(done), 0); // Single cycle pulse
		if (wb)
			ref_regs[b] = inc ? base_value + ldst_pkg::word'(4 * n)
			                  : base_value - ldst_pkg::word'(4 * n);
		compare_registers();
	endtask

	task automatic check_after_reset();
		step();
		check_value("busy", 32'(busy), 0);
		check_value("done", 32'(done), 0);
		check_value("mem_start", 32'(mem_start), 0);
		check_value("mem_write", 32'(mem_write), 0);
		check_value("mem_addr", 32'(mem_addr), 0);
		compare_registers();
	endtask

	// Every register gets a distinct word aligned value
	task automatic preload_registers();
		for (int i = 0; i < ldst_pkg::NUM_REGS; i++)
			mem_model[ldst_pkg::ptr'(i)] = 32'h1000 * (i + 1);
		run_insn(1'b1, 1'b0, 1'b1, 1'b0, 4'd0, 16'hffff, 1'b0);
	endtask

	task automatic store_increment_post();
		run_insn(1'b0, 1'b0, 1'b1, 1'b0, 4'd3, 16'h4a26, 1'b0);
	endtask

	task automatic load_decrement_pre_writeback();
		run_insn(1'b1, 1'b1, 1'b0, 1'b1, 4'd4, 16'h0c31, 1'b0);
	endtask

	task automatic random_loads();
		ldst_pkg::reg_list list;
		ldst_pkg::reg_num b;
		logic wb, up;
		for (int i = 0; i < RANDOM_RUNS; i++) begin
			list = ldst_pkg::reg_list'(random_bits(16));
			b = ldst_pkg::reg_num'(random_bits(4));
			wb = lfsr_bit();
			up = (i % 2) == 0;
			if (i < 2) begin
				list[b] = 1'b1; // Base in the list so writeback has to win
				wb = 1'b1;
			end
			run_insn(1'b1, up, up, wb, b, list, 1'b0);
		end
	endtask

	task automatic empty_list();
		run_insn(1'b1, 1'b1, 1'b0, 1'b1, 4'd5, 16'h0000, 1'b0);
	endtask

	task automatic issue_while_busy();
		run_insn(1'b1, 1'b0, 1'b1, 1'b0, 4'd2, 16'h00f0, 1'b1);
	endtask

	initial begin
		int waited;
		issue = 1'b0;
		load = 1'b0;
		pre_indexed = 1'b0;
		increment = 1'b0;
		writeback = 1'b0;
		base = '0;
		regs = '0;
		mem_ready = 1'b0;
		mem_data_rd = '0;
		dbg_num = '0;
		for (int i = 0; i < ldst_pkg::NUM_REGS; i++)
			ref_regs[i] = '0;
		waited = 0;
		while (rst_n !== 1'b1) begin
			if (waited == TIMEOUT)
				fail_stop("Reset was never released");
			waited++;
			@(posedge clk);
		end
		check_after_reset();
		preload_registers();
		store_increment_post();
		load_decrement_pre_writeback();
		random_loads();
		empty_list();
		issue_while_busy();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/ldst_tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module ldst_tb_clock
(
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Released just after an edge so no flop sees it move at the edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire
